// File: Makefile
SIM     ?= verilator
FLAGS   ?= --binary --timing --assert -Wno-fatal
TOP     ?= tb_output_vs
FLIST   ?= flist.f
OBJ_DIR ?= obj_dir
LOG     ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_output_vs.sv
/*
  Testbench for output_vs_interface.
  Packets come from bench/testdata_packets.txt, so run from the project root.
  Inputs change on the falling edge; outputs are sampled 1 ns later,
  which is what transfers on the next rising edge.
*/
`timescale 1ns/1ns
`include "oq_settings.svh"

module tb_output_vs;

  localparam int RESET_CYCLES = 8;
  localparam int MAX_PKT      = 64;

  typedef logic [`NUM_OUT-1:0] port_mask_t;

  logic axis_aclk = 1'b0;
  logic axis_resetn;
  stream_pkg::data_t  [`NUM_IN-1:0]  s_axis_tdata;
  stream_pkg::keep_t  [`NUM_IN-1:0]  s_axis_tkeep;
  stream_pkg::tuser_t [`NUM_IN-1:0]  s_axis_tuser;
  logic [`NUM_IN-1:0] s_axis_tlast, s_axis_tvalid, s_axis_tready;
  stream_pkg::data_t  [`NUM_OUT-1:0] m_axis_tdata;
  stream_pkg::keep_t  [`NUM_OUT-1:0] m_axis_tkeep;
  stream_pkg::tuser_t [`NUM_OUT-1:0] m_axis_tuser;
  logic [`NUM_OUT-1:0] m_axis_tlast, m_axis_tvalid, m_axis_tready, pkt_removed;
  logic pkt_dropped;

  logic [7:0]        pkt_mem [4*MAX_PKT];
  stream_pkg::beat_t tx_q [`NUM_IN][$];
  stream_pkg::beat_t exp_q [`NUM_IN][$];
  int removed_cnt [`NUM_OUT];
  int exp_removed [`NUM_OUT];
  int dropped_cnt, exp_dropped, num_pkts, total_beats, cur_src;
  int errors, tests_failed, cycle, watchdog_ns;
  // 0 output ready high, 1 random, 2 low for stall_cycles then high
  int ready_mode;
  int stall_cycles;
  bit check_idle, in_pkt, saw_full;
  logic [31:0] rng = 32'hf11d_1475;

  output_vs_interface dut_i (.*);

  always #2 axis_aclk = ~axis_aclk;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_value(string name, logic [63:0] want, logic [63:0] got);
    assert (got === want) else begin
      $display("FAIL %s expected %h got %h", name, want, got);
      errors++;
    end
  endtask

  // Source field sits in tuser bits 7..4
  task automatic check_beat(int p);
    stream_pkg::beat_t want;
    int src;
    src = int'(m_axis_tuser[p][7:4]);
    assert (src < `NUM_IN && exp_q[src].size() > 0) else begin
      $display("Unexpected beat on output %0d with tuser %h", p, m_axis_tuser[p]);
      errors++;
    end
    if (src < `NUM_IN && exp_q[src].size() > 0) begin
      want = exp_q[src].pop_front();
      compare_value("m_axis_tdata", want.data, m_axis_tdata[p]);
      compare_value("m_axis_tkeep", want.keep, m_axis_tkeep[p]);
      compare_value("m_axis_tuser", want.tuser, m_axis_tuser[p]);
      compare_value("m_axis_tlast", want.last, m_axis_tlast[p]);
      compare_value("output port", want.tuser[3:0], p);
    end
    assert (!(in_pkt && src != cur_src)) else begin
      $display("Packet from source %0d cut into packet from source %0d", src, cur_src);
      errors++;
    end
    in_pkt  = !m_axis_tlast[p];
    cur_src = src;
  endtask

  task automatic step();
    @(negedge axis_aclk);
    if (cycle == RESET_CYCLES - 1) begin
      axis_resetn = 1'b1;
    end
    cycle++;
    for (int s = 0; s < `NUM_IN; s++) begin
      s_axis_tvalid[s] = (tx_q[s].size() > 0);
      if (tx_q[s].size() > 0) begin
        s_axis_tdata[s] = tx_q[s][0].data;
        s_axis_tkeep[s] = tx_q[s][0].keep;
        s_axis_tuser[s] = tx_q[s][0].tuser;
        s_axis_tlast[s] = tx_q[s][0].last;
      end
    end
    case (ready_mode)
      0: m_axis_tready = '1;
      1: begin
        rng = xorshift(rng);
        m_axis_tready = port_mask_t'(rng);
      end
      default: begin
        m_axis_tready = (stall_cycles > 0) ? '0 : '1;
        if (stall_cycles > 0) begin
          stall_cycles--;
        end
      end
    endcase
    #1;
    for (int s = 0; s < `NUM_IN; s++) begin
      if (s_axis_tvalid[s] && s_axis_tready[s]) begin
        void'(tx_q[s].pop_front());
      end else if (s_axis_tvalid[s]) begin
        saw_full = 1'b1;
      end
    end
    for (int p = 0; p < `NUM_OUT; p++) begin
      if (m_axis_tvalid[p] === 1'b1 && m_axis_tready[p]) begin
        check_beat(p);
      end
      removed_cnt[p] += (pkt_removed[p] === 1'b1);
    end
    dropped_cnt += (pkt_dropped === 1'b1);
    if (check_idle) begin
      compare_value("m_axis_tvalid", '0, m_axis_tvalid);
      compare_value("pkt_removed", '0, pkt_removed);
      compare_value("pkt_dropped", '0, pkt_dropped);
    end
  endtask

  // Words are generated in file order, one xorshift step each
  task automatic load_test(int t);
    stream_pkg::beat_t b;
    int src, dst, len;
    removed_cnt = '{default: 0};
    exp_removed = '{default: 0};
    dropped_cnt = 0;
    exp_dropped = 0;
    saw_full    = 1'b0;
    for (int i = 0; i < num_pkts; i++) begin
      if (pkt_mem[4*i] == t) begin
        src = int'(pkt_mem[4*i+1]);
        dst = int'(pkt_mem[4*i+2]);
        len = int'(pkt_mem[4*i+3]);
        for (int k = 0; k < len; k++) begin
          rng     = xorshift(rng);
          b.data  = stream_pkg::data_t'({rng, 8'(t), 8'(src), 16'(k)});
          b.last  = (k == len - 1);
          b.keep  = b.last ? stream_pkg::keep_t'(4'hf) : '1;
          b.tuser = stream_pkg::tuser_t'({4'(src), 4'(dst)});
          tx_q[src].push_back(b);
          if (dst < `NUM_OUT) begin
            exp_q[src].push_back(b);
          end
        end
        if (dst < `NUM_OUT) begin
          exp_removed[dst]++;
        end else begin
          exp_dropped++;
        end
      end
    end
  endtask

  function automatic bit all_done();
    bit done;
    done = (dropped_cnt >= exp_dropped);
    for (int s = 0; s < `NUM_IN; s++) begin
      if (tx_q[s].size() != 0 || exp_q[s].size() != 0) begin
        done = 1'b0;
      end
    end
    for (int p = 0; p < `NUM_OUT; p++) begin
      if (removed_cnt[p] < exp_removed[p]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic finish_test(int t, int errs_before);
    if (errors == errs_before) begin
      $display("test %0d passed", t);
    end else begin
      $display("test %0d failed with %0d errors", t, errors - errs_before);
      tests_failed++;
    end
  endtask

  task automatic run_test(int t);
    int errs_before;
    errs_before = errors;
    load_test(t);
    case (t)
      2, 3: ready_mode = 0;
      6: begin
        ready_mode   = 2;
        stall_cycles = 2 << `FIFO_DEPTH_BITS;
      end
      default: ready_mode = 1;
    endcase
    while (!all_done()) begin
      step();
    end
    // Room for a late or extra end-of-packet pulse
    repeat (2) step();
    for (int p = 0; p < `NUM_OUT; p++) begin
      compare_value($sformatf("pkt_removed[%0d] count", p), exp_removed[p], removed_cnt[p]);
    end
    compare_value("pkt_dropped count", exp_dropped, dropped_cnt);
    if (t == 6) begin
      assert (saw_full) else begin
        $display("Input ready never went low while the outputs were stalled");
        errors++;
      end
    end
    finish_test(t, errs_before);
  endtask

  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("Timeout: run still busy after %0d ns", watchdog_ns);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    axis_resetn   = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tuser  = '0;
    s_axis_tlast  = '0;
    s_axis_tvalid = '0;
    m_axis_tready = '0;
    foreach (pkt_mem[i]) begin
      pkt_mem[i] = 8'hff;
    end
    $readmemh("bench/testdata_packets.txt", pkt_mem);
    while (num_pkts < MAX_PKT && pkt_mem[4*num_pkts] != 8'hff) begin
      total_beats += int'(pkt_mem[4*num_pkts+3]);
      num_pkts++;
    end
    assert (num_pkts > 0) else begin
      $display("No packets found in bench/testdata_packets.txt");
      errors++;
    end
    watchdog_ns = 200 + 40 * total_beats;
    // Reset and a few idle cycles after it
    check_idle = 1'b1;
    repeat (RESET_CYCLES + 4) step();
    check_idle = 1'b0;
    finish_test(1, 0);
    for (int t = 2; t <= 6; t++) begin
      run_test(t);
    end
    $display("tests run 6, failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: bench/testdata_packets.txt
// Columns: test number, source, destination, length in beats (all hex)
// Destinations of 2 and above have no output port and are dropped
2 1 1 5
3 0 0 4
3 1 1 3
3 2 0 6
3 3 1 1
3 0 1 2
3 1 0 7
4 0 1 5
4 1 0 2
4 2 1 8
4 3 0 3
4 0 0 1
4 1 1 6
5 0 2 4
5 0 1 3
5 1 0 2
5 1 f 1
5 1 1 5
5 2 3 6
5 2 0 2
6 2 1 8
6 2 0 7
6 2 1 6

// File: design/beat_if.sv
/*
  One stream beat with valid/ready handshake.
  A beat moves on a rising edge with valid and ready both high.
  The source must not derive valid from ready.
*/
`timescale 1ns/1ns

interface beat_if;

  stream_pkg::beat_t beat;
  logic              valid;
  logic              ready;

  // Producer side
  modport src (
    output beat,
    output valid,
    input  ready
  );

  // Consumer side
  modport snk (
    input  beat,
    input  valid,
    output ready
  );

endinterface

// File: design/egress_steer.sv
/*
  Steers each packet to the output port named in tuser bits 3..0.
  Destinations of NUM_OUT or above are drained at one beat per cycle.
  The port is fixed by the first beat; later tuser values are ignored.
  Back-pressure from the chosen port stalls the whole upstream path.
*/
`timescale 1ns/1ns
`include "oq_settings.svh"

module egress_steer (
  input  logic                                axis_aclk,
  input  logic                                axis_resetn,
  beat_if.snk                                 pkt_in,
  output stream_pkg::data_t  [`NUM_OUT-1:0]   m_axis_tdata,
  output stream_pkg::keep_t  [`NUM_OUT-1:0]   m_axis_tkeep,
  output stream_pkg::tuser_t [`NUM_OUT-1:0]   m_axis_tuser,
  output logic               [`NUM_OUT-1:0]   m_axis_tlast,
  output logic               [`NUM_OUT-1:0]   m_axis_tvalid,
  input  logic               [`NUM_OUT-1:0]   m_axis_tready,
  output logic               [`NUM_OUT-1:0]   pkt_removed,
  output logic                                pkt_dropped
);

  sched_pkg::steer_state_e state;
  stream_pkg::dst_t        head_dst;
  stream_pkg::dst_t        port_q;
  stream_pkg::dst_t        sel;
  logic                    dst_ok;
  logic                    fwd;
  logic                    drain;
  logic                    accept;
  logic [`NUM_OUT-1:0]     port_hit;

  assign head_dst = stream_pkg::tuser_dst(pkt_in.beat.tuser);
  assign dst_ok   = int'(head_dst) < `NUM_OUT;

  // Head beat decides from its own tuser, later beats use the latched port
  always_comb begin
    sel   = port_q;
    fwd   = 1'b0;
    drain = 1'b0;
    case (state)
      sched_pkg::ST_HEAD: begin
        sel   = head_dst;
        fwd   = dst_ok;
        drain = !dst_ok;
      end
      sched_pkg::ST_FORWARD: fwd   = 1'b1;
      sched_pkg::ST_DRAIN:   drain = 1'b1;
      default: ;
    endcase
  end

  for (genvar p = 0; p < `NUM_OUT; p++) begin : g_port
    assign port_hit[p]      = fwd && (sel == stream_pkg::dst_t'(p));
    assign m_axis_tvalid[p] = pkt_in.valid && port_hit[p];
    assign m_axis_tdata[p]  = pkt_in.beat.data;
    assign m_axis_tkeep[p]  = pkt_in.beat.keep;
    assign m_axis_tuser[p]  = pkt_in.beat.tuser;
    assign m_axis_tlast[p]  = pkt_in.beat.last;
  end

  assign pkt_in.ready = drain || |(port_hit & m_axis_tready);
  assign accept       = pkt_in.valid && pkt_in.ready;

  always_ff @(posedge axis_aclk) begin
    if (state == sched_pkg::ST_HEAD && accept) begin
      port_q <= head_dst;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state       <= sched_pkg::ST_HEAD;
      pkt_removed <= '0;
      pkt_dropped <= 1'b0;
    end else begin
      pkt_removed <= '0;
      pkt_dropped <= 1'b0;
      if (accept) begin
        if (pkt_in.beat.last) begin
          state <= sched_pkg::ST_HEAD;
          // One-cycle end-of-packet pulses
          if (fwd) begin
            pkt_removed <= port_hit;
          end else begin
            pkt_dropped <= 1'b1;
          end
        end else if (state == sched_pkg::ST_HEAD) begin
          state <= fwd ? sched_pkg::ST_FORWARD : sched_pkg::ST_DRAIN;
        end
      end
    end
  end

endmodule

// File: design/ingress_fifo.sv
/*
  First-word-fall-through queue for one stream input.
  in_ready drops once DEPTH-1 words are stored, so the queue never fills.
  A beat offered while in_ready is low is ignored; the sender holds it.
  Storage is plain registers with a combinational head read.
*/
`timescale 1ns/1ns
`include "oq_settings.svh"

module ingress_fifo (
  input  logic               axis_aclk,
  input  logic               axis_resetn,
  input  stream_pkg::data_t  in_data,
  input  stream_pkg::keep_t  in_keep,
  input  stream_pkg::tuser_t in_user,
  input  logic               in_last,
  input  logic               in_valid,
  output logic               in_ready,
  beat_if.src                out
);

  localparam int PTR_W = `FIFO_DEPTH_BITS;
  localparam int DEPTH = 1 << PTR_W;

  stream_pkg::beat_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             nearly_full;
  logic             wr_en;
  logic             rd_en;

  assign nearly_full = (count >= (PTR_W+1)'(DEPTH - 1));
  assign in_ready    = ~nearly_full;
  assign wr_en       = in_valid && in_ready;
  assign rd_en       = out.valid && out.ready;

  // Head word is visible as soon as it is stored
  assign out.valid = (count != '0);
  assign out.beat  = mem[rd_ptr];

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_ptr] <= '{data: in_data, keep: in_keep, tuser: in_user, last: in_last};
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: design/oq_settings.svh
/*
  Build-time sizing for the output port switch.
  NUM_OUT must stay below 16, since the destination field is 4 bits.
  FIFO_DEPTH_BITS sets the ingress queue depth as a power of two.
  Back-pressure starts one word below the full depth.
*/
`ifndef OQ_SETTINGS_SVH
`define OQ_SETTINGS_SVH

// Stream inputs, each with its own ingress queue
`define NUM_IN 4

// Output ports reachable through the destination field
`define NUM_OUT 2

// Word widths; tkeep is DATA_W/8
`define DATA_W 64
`define TUSER_W 16

// Ingress queue depth is 2**FIFO_DEPTH_BITS words
`define FIFO_DEPTH_BITS 4

`endif

// File: design/output_vs_interface.sv
/*
  Output switch top level: NUM_IN ingress queues, a packet round-robin
  arbiter and a steering stage onto NUM_OUT ports.
  There is no output buffering; a stalled port blocks all inputs.
  Latency from input to output depends on arbitration order.
  Statistics are single-cycle pulses, one per packet.
*/
`timescale 1ns/1ns
`include "oq_settings.svh"

module output_vs_interface (
  input  logic                                axis_aclk,
  input  logic                                axis_resetn,

  // Input streams, one per ingress queue
  input  stream_pkg::data_t  [`NUM_IN-1:0]    s_axis_tdata,
  input  stream_pkg::keep_t  [`NUM_IN-1:0]    s_axis_tkeep,
  input  stream_pkg::tuser_t [`NUM_IN-1:0]    s_axis_tuser,
  input  logic               [`NUM_IN-1:0]    s_axis_tlast,
  input  logic               [`NUM_IN-1:0]    s_axis_tvalid,
  output logic               [`NUM_IN-1:0]    s_axis_tready,

  // Output ports
  output stream_pkg::data_t  [`NUM_OUT-1:0]   m_axis_tdata,
  output stream_pkg::keep_t  [`NUM_OUT-1:0]   m_axis_tkeep,
  output stream_pkg::tuser_t [`NUM_OUT-1:0]   m_axis_tuser,
  output logic               [`NUM_OUT-1:0]   m_axis_tlast,
  output logic               [`NUM_OUT-1:0]   m_axis_tvalid,
  input  logic               [`NUM_OUT-1:0]   m_axis_tready,

  // Statistics
  output logic               [`NUM_OUT-1:0]   pkt_removed,
  output logic                                pkt_dropped
);

  beat_if q_if [`NUM_IN] ();
  beat_if pkt_if ();

  for (genvar i = 0; i < `NUM_IN; i++) begin : g_ingress
    ingress_fifo ingress_i (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .in_data     (s_axis_tdata[i]),
      .in_keep     (s_axis_tkeep[i]),
      .in_user     (s_axis_tuser[i]),
      .in_last     (s_axis_tlast[i]),
      .in_valid    (s_axis_tvalid[i]),
      .in_ready    (s_axis_tready[i]),
      .out         (q_if[i])
    );
  end

  rr_packet_arbiter arbiter_i (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .q_in        (q_if),
    .pkt_out     (pkt_if)
  );

  egress_steer steer_i (
    .axis_aclk     (axis_aclk),
    .axis_resetn   (axis_resetn),
    .pkt_in        (pkt_if),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tkeep  (m_axis_tkeep),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .pkt_removed   (pkt_removed),
    .pkt_dropped   (pkt_dropped)
  );

endmodule

// File: design/rr_packet_arbiter.sv
/*
  Round-robin arbiter that serves one whole packet per grant.
  The pointer only moves after a last beat, or while idle on an empty queue.
  A queue that never sends its last beat holds the output indefinitely.
*/
`timescale 1ns/1ns
`include "oq_settings.svh"

module rr_packet_arbiter (
  input  logic axis_aclk,
  input  logic axis_resetn,
  beat_if.snk  q_in [`NUM_IN],
  beat_if.src  pkt_out
);

  sched_pkg::arb_state_e  state;
  sched_pkg::arb_state_e  state_next;
  stream_pkg::queue_idx_t cur_q;
  stream_pkg::queue_idx_t cur_next;
  stream_pkg::queue_idx_t cur_plus1;

  stream_pkg::beat_t  head [`NUM_IN];
  logic [`NUM_IN-1:0] head_valid;
  logic               accept;

  // Interface arrays need constant indices, so flatten them here
  for (genvar i = 0; i < `NUM_IN; i++) begin : g_queue
    assign head[i]        = q_in[i].beat;
    assign head_valid[i]  = q_in[i].valid;
    assign q_in[i].ready  = pkt_out.ready && (cur_q == stream_pkg::queue_idx_t'(i));
  end

  assign cur_plus1 = (cur_q == stream_pkg::queue_idx_t'(`NUM_IN - 1)) ? '0 : cur_q + 1'b1;

  // Current head passes straight through
  assign pkt_out.beat  = head[cur_q];
  assign pkt_out.valid = head_valid[cur_q];
  assign accept        = pkt_out.valid && pkt_out.ready;

  always_comb begin
    state_next = state;
    cur_next   = cur_q;
    case (state)
      sched_pkg::ARB_IDLE: begin
        if (!head_valid[cur_q]) begin
          // Skip empty queues one step per cycle
          cur_next = cur_plus1;
        end else if (accept) begin
          if (pkt_out.beat.last) begin
            // Single-beat packet
            cur_next = cur_plus1;
          end else begin
            state_next = sched_pkg::ARB_PKT;
          end
        end
      end
      sched_pkg::ARB_PKT: begin
        if (accept && pkt_out.beat.last) begin
          state_next = sched_pkg::ARB_IDLE;
          cur_next   = cur_plus1;
        end
      end
      default: begin
        state_next = sched_pkg::ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state <= sched_pkg::ARB_IDLE;
      cur_q <= '0;
    end else begin
      state <= state_next;
      cur_q <= cur_next;
    end
  end

endmodule

// File: design/sched_pkg.sv
/*
  State encodings for packet arbitration and output steering.
*/

package sched_pkg;

  // Round-robin arbiter, between packets or inside one
  typedef enum logic {
    ARB_IDLE,
    ARB_PKT
  } arb_state_e;

  // Steering stage, per packet
  typedef enum logic [1:0] {
    ST_HEAD,
    ST_FORWARD,
    ST_DRAIN
  } steer_state_e;

endpackage

// File: design/stream_pkg.sv
/*
  Stream word types shared by the queues, arbiter and steering stage.
  tuser layout: bits 3..0 destination port, bits 7..4 source.
  Upper tuser bits are carried through untouched.
*/
`include "oq_settings.svh"

package stream_pkg;

  typedef logic [`DATA_W-1:0]          data_t;
  typedef logic [`DATA_W/8-1:0]        keep_t;
  typedef logic [`TUSER_W-1:0]         tuser_t;
  typedef logic [3:0]                  dst_t;
  typedef logic [3:0]                  src_t;
  typedef logic [$clog2(`NUM_IN)-1:0]  queue_idx_t;

  localparam int DST_LSB = 0;
  localparam int SRC_LSB = 4;

  // One stored queue word
  typedef struct packed {
    data_t  data;
    keep_t  keep;
    tuser_t tuser;
    logic   last;
  } beat_t;

  function automatic dst_t tuser_dst(tuser_t user);
    return user[DST_LSB +: $bits(dst_t)];
  endfunction

  function automatic src_t tuser_src(tuser_t user);
    return user[SRC_LSB +: $bits(src_t)];
  endfunction

endpackage

// File: flist.f
+incdir+design
design/stream_pkg.sv
design/sched_pkg.sv
design/beat_if.sv
design/ingress_fifo.sv
design/rr_packet_arbiter.sv
design/egress_steer.sv
design/output_vs_interface.sv
bench/tb_output_vs.sv
